/* hdl/cgra_xcel_pkg.sv */
`default_nettype none

package cgra_xcel_pkg;

  // Request opcodes
  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_ADD   = 2'd2
  } xcel_op_e;

  // Response status codes
  typedef enum logic [1:0] {
    RSP_STORE_ACK = 2'd0,
    RSP_LOAD_DATA = 2'd1,
    RSP_ADD_OLD   = 2'd2,
    RSP_BAD_DEST  = 2'd3
  } xcel_rsp_e;

  // Endpoint FSM, one request in flight
  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_EXEC = 2'd1,
    S_RESP = 2'd2
  } xcel_state_e;

  localparam int SPAD_WORDS = 256;

  // Fixed column of the pod on the mesh edge
  localparam int POD_X_CORD = 'h20;

endpackage

`default_nettype wire

/* hdl/noc_link_pkg.sv */
`default_nettype none

package noc_link_pkg;

  import cgra_xcel_pkg::*;

  // ============================================================
  // Link geometry
  // ============================================================

  localparam int NUM_LANES = 4;
  localparam int Y_CORD_W  = 7;
  localparam int X_CORD_W  = 7;
  localparam int ADDR_W    = 8;
  localparam int DATA_W    = 32;

  // ============================================================
  // Buffering and credit flow
  // ============================================================

  // Receiver depth is also the initial credit of the sender
  localparam int RX_FIFO_DEPTH       = 8;
  localparam int TX_FIFO_DEPTH       = 4;
  localparam int LG_TOKEN_DECIMATION = 2;
  localparam int TOKEN_CREDITS       = 1 << LG_TOKEN_DECIMATION;
  localparam int CREDIT_W            = $clog2(RX_FIFO_DEPTH + 1);
  localparam int RX_PTR_W            = $clog2(RX_FIFO_DEPTH);
  localparam int TX_PTR_W            = $clog2(TX_FIFO_DEPTH);

  // Request packet on the forward channel
  typedef struct packed {
    xcel_op_e            opcode;
    logic [Y_CORD_W-1:0] dst_y;
    logic [X_CORD_W-1:0] src_x;
    logic [Y_CORD_W-1:0] src_y;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } fwd_pkt_s;

  // Response packet on the reverse channel
  typedef struct packed {
    xcel_rsp_e           status;
    logic [X_CORD_W-1:0] dst_x;
    logic [Y_CORD_W-1:0] dst_y;
    logic [DATA_W-1:0]   data;
  } rev_pkt_s;

endpackage

`default_nettype wire

/* hdl/link_sdr_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module link_sdr_rx (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   link_v_i,
  input  noc_link_pkg::fwd_pkt_s link_data_i,
  output logic                   link_token_o,
  input  logic                   rx_pop_i,
  output noc_link_pkg::fwd_pkt_s rx_pkt_o,
  output logic                   rx_empty_o
);

  import noc_link_pkg::*;

  fwd_pkt_s                       fifo_mem [RX_FIFO_DEPTH];
  logic [RX_PTR_W-1:0]            wr_ptr;
  logic [RX_PTR_W-1:0]            rd_ptr;
  logic [RX_PTR_W:0]              count;
  logic                           wr_en;
  logic                           pop;
  logic [LG_TOKEN_DECIMATION-1:0] consumed_cnt;
  logic                           token_q;

  // ============================================================
  // Packet FIFO
  // ============================================================

  // Sender only strobes with credit, so full is a guard only
  assign wr_en      = link_v_i && (count != RX_FIFO_DEPTH);
  assign rx_empty_o = (count == '0);
  assign pop        = rx_pop_i && !rx_empty_o;
  assign rx_pkt_o   = fifo_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      fifo_mem[wr_ptr] <= link_data_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ============================================================
  // Token return
  // ============================================================

  // One token per 2**LG_TOKEN_DECIMATION consumed packets
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      consumed_cnt <= '0;
      token_q      <= 1'b0;
    end else begin
      token_q <= pop && (consumed_cnt == '1);
      if (pop) begin
        consumed_cnt <= consumed_cnt + 1'b1;
      end
    end
  end

  assign link_token_o = token_q;

endmodule

`default_nettype wire

/* hdl/link_sdr_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module link_sdr_tx (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  noc_link_pkg::rev_pkt_s rsp_pkt_i,
  input  logic                   rsp_v_i,
  output logic                   tx_full_o,
  output logic                   link_v_o,
  output noc_link_pkg::rev_pkt_s link_data_o,
  input  logic                   link_token_i
);

  import noc_link_pkg::*;

  rev_pkt_s            fifo_mem [TX_FIFO_DEPTH];
  logic [TX_PTR_W-1:0] wr_ptr;
  logic [TX_PTR_W-1:0] rd_ptr;
  logic [TX_PTR_W:0]   count;
  logic [CREDIT_W-1:0] credits;
  logic [CREDIT_W-1:0] credit_add;
  logic                send;
  logic                link_v_q;
  rev_pkt_s            link_data_q;

  // ============================================================
  // Response FIFO
  // ============================================================

  assign tx_full_o = (count == TX_FIFO_DEPTH);

  // Head leaves only while the far receiver has room
  assign send = (count != '0) && (credits != '0);

  always_ff @(posedge clk_i) begin
    if (rsp_v_i) begin
      fifo_mem[wr_ptr] <= rsp_pkt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (rsp_v_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rsp_v_i, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ============================================================
  // Credit counter and link register
  // ============================================================

  assign credit_add = link_token_i ? CREDIT_W'(TOKEN_CREDITS) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits  <= CREDIT_W'(RX_FIFO_DEPTH);
      link_v_q <= 1'b0;
    end else begin
      credits  <= credits + credit_add - CREDIT_W'(send);
      link_v_q <= send;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      link_data_q <= fifo_mem[rd_ptr];
    end
  end

  assign link_v_o    = link_v_q;
  assign link_data_o = link_data_q;

endmodule

`default_nettype wire

/* hdl/xcel_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

module xcel_endpoint (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic [noc_link_pkg::Y_CORD_W-1:0] my_y_i,
  input  noc_link_pkg::fwd_pkt_s            rx_pkt_i,
  input  logic                              rx_empty_i,
  output logic                              rx_pop_o,
  input  logic                              tx_full_i,
  output noc_link_pkg::rev_pkt_s            rsp_pkt_o,
  output logic                              rsp_v_o
);

  import cgra_xcel_pkg::*;
  import noc_link_pkg::*;

  xcel_state_e           state_q;
  xcel_state_e           state_d;
  fwd_pkt_s              req_q;
  logic [DATA_W-1:0]     old_q;
  logic [DATA_W-1:0]     spad_mem [SPAD_WORDS];
  logic [SPAD_WORDS-1:0] spad_valid;
  logic                  row_ok;
  logic                  fire;
  logic                  wr_en;
  logic [DATA_W-1:0]     wr_data;
  rev_pkt_s              rsp;

  // ============================================================
  // Control FSM
  // ============================================================

  assign rx_pop_o = (state_q == S_IDLE) && !rx_empty_i;
  assign fire     = (state_q == S_RESP) && !tx_full_i;
  assign rsp_v_o  = fire;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (!rx_empty_i) begin
          state_d = S_EXEC;
        end
      end
      S_EXEC: state_d = S_RESP;
      S_RESP: begin
        // Hold here while the transmitter is full
        if (!tx_full_i) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture on pop, scratchpad read in S_EXEC
  always_ff @(posedge clk_i) begin
    if (rx_pop_o) begin
      req_q <= rx_pkt_i;
    end
    if (state_q == S_EXEC) begin
      old_q <= spad_valid[req_q.addr] ? spad_mem[req_q.addr] : '0;
    end
  end

  // ============================================================
  // Decode and response
  // ============================================================

  assign row_ok = (req_q.dst_y == my_y_i);

  always_comb begin
    wr_en      = 1'b0;
    wr_data    = req_q.data;
    rsp.dst_x  = req_q.src_x;
    rsp.dst_y  = req_q.src_y;
    rsp.status = RSP_LOAD_DATA;
    rsp.data   = old_q;
    if (!row_ok) begin
      // Wrong row, memory untouched
      rsp.status = RSP_BAD_DEST;
      rsp.data   = '0;
    end else begin
      case (req_q.opcode)
        OP_STORE: begin
          wr_en      = 1'b1;
          rsp.status = RSP_STORE_ACK;
          rsp.data   = req_q.data;
        end
        OP_ADD: begin
          wr_en      = 1'b1;
          wr_data    = old_q + req_q.data;
          rsp.status = RSP_ADD_OLD;
        end
        default: begin
          rsp.status = RSP_LOAD_DATA;
        end
      endcase
    end
  end

  assign rsp_pkt_o = rsp;

  // Write lands together with the response strobe
  always_ff @(posedge clk_i) begin
    if (fire && wr_en) begin
      spad_mem[req_q.addr] <= wr_data;
    end
  end

  // Unwritten words read as zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      spad_valid <= '0;
    end else if (fire && wr_en) begin
      spad_valid[req_q.addr] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/cgra_pod.sv */
`timescale 1ns/1ps
`default_nettype none

module cgra_pod (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [noc_link_pkg::NUM_LANES-1:0][noc_link_pkg::Y_CORD_W-1:0] global_y_cord_i,

  input  logic [noc_link_pkg::NUM_LANES-1:0]  link_fwd_v_i,
  input  noc_link_pkg::fwd_pkt_s [noc_link_pkg::NUM_LANES-1:0] link_fwd_data_i,
  output logic [noc_link_pkg::NUM_LANES-1:0]  link_fwd_token_o,

  output logic [noc_link_pkg::NUM_LANES-1:0]  link_rev_v_o,
  output noc_link_pkg::rev_pkt_s [noc_link_pkg::NUM_LANES-1:0] link_rev_data_o,
  input  logic [noc_link_pkg::NUM_LANES-1:0]  link_rev_token_i
);

  import noc_link_pkg::*;

  logic                     reset_r;
  fwd_pkt_s [NUM_LANES-1:0] rx_pkt;
  logic [NUM_LANES-1:0]     rx_empty;
  logic [NUM_LANES-1:0]     rx_pop;
  rev_pkt_s [NUM_LANES-1:0] rsp_pkt;
  logic [NUM_LANES-1:0]     rsp_v;
  logic [NUM_LANES-1:0]     tx_full;

  // ============================================================
  // Reset register
  // ============================================================

  // Registered once for timing, all lanes see the same copy
  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
  end

  // ============================================================
  // Lanes
  // ============================================================

  for (genvar i = 0; i < NUM_LANES; i++) begin : lanes
    link_sdr_rx rx (
      .clk_i        (clk_i),
      .reset_i      (reset_r),
      .link_v_i     (link_fwd_v_i[i]),
      .link_data_i  (link_fwd_data_i[i]),
      .link_token_o (link_fwd_token_o[i]),
      .rx_pop_i     (rx_pop[i]),
      .rx_pkt_o     (rx_pkt[i]),
      .rx_empty_o   (rx_empty[i])
    );

    xcel_endpoint xcel (
      .clk_i      (clk_i),
      .reset_i    (reset_r),
      .my_y_i     (global_y_cord_i[i]),
      .rx_pkt_i   (rx_pkt[i]),
      .rx_empty_i (rx_empty[i]),
      .rx_pop_o   (rx_pop[i]),
      .tx_full_i  (tx_full[i]),
      .rsp_pkt_o  (rsp_pkt[i]),
      .rsp_v_o    (rsp_v[i])
    );

    link_sdr_tx tx (
      .clk_i        (clk_i),
      .reset_i      (reset_r),
      .rsp_pkt_i    (rsp_pkt[i]),
      .rsp_v_i      (rsp_v[i]),
      .tx_full_o    (tx_full[i]),
      .link_v_o     (link_rev_v_o[i]),
      .link_data_o  (link_rev_data_o[i]),
      .link_token_i (link_rev_token_i[i])
    );
  end

endmodule

`default_nettype wire

/* tests/cgra_pod_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cgra_pod_tb;

  import cgra_xcel_pkg::*;
  import noc_link_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int MAX_REQS   = 64;
  localparam int STALL_LANE = 3;

  // One table row per request with the status it must get back
  typedef struct packed {
    logic [1:0]          lane;
    xcel_op_e            opcode;
    logic [Y_CORD_W-1:0] dst_y;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    xcel_rsp_e           status;
  } req_entry_s;

  logic                                 clk_i;
  logic                                 reset_i;
  logic [NUM_LANES-1:0][Y_CORD_W-1:0]   global_y_cord_i;
  logic [NUM_LANES-1:0]                 link_fwd_v_i;
  fwd_pkt_s [NUM_LANES-1:0]             link_fwd_data_i;
  logic [NUM_LANES-1:0]                 link_fwd_token_o;
  logic [NUM_LANES-1:0]                 link_rev_v_o;
  rev_pkt_s [NUM_LANES-1:0]             link_rev_data_o;
  logic [NUM_LANES-1:0]                 link_rev_token_i;

  req_entry_s        req_tbl [MAX_REQS];
  int                num_reqs;
  logic              table_built;
  logic [DATA_W-1:0] ref_mem [NUM_LANES][SPAD_WORDS];
  rev_pkt_s          exp_mem [NUM_LANES][MAX_REQS];
  int                exp_wr [NUM_LANES];
  int                exp_rd [NUM_LANES];
  int                sent [NUM_LANES];
  int                fwd_tokens [NUM_LANES];
  int                rcv_count [NUM_LANES];
  int                rev_tokens_sent [NUM_LANES];
  logic [NUM_LANES-1:0] rev_stall;

  cgra_pod cgra_pod_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .global_y_cord_i  (global_y_cord_i),
    .link_fwd_v_i     (link_fwd_v_i),
    .link_fwd_data_i  (link_fwd_data_i),
    .link_fwd_token_o (link_fwd_token_o),
    .link_rev_v_o     (link_rev_v_o),
    .link_rev_data_o  (link_rev_data_o),
    .link_rev_token_i (link_rev_token_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ============================================================
  // Helpers and compare tasks
  // ============================================================

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_rev_pkt(input string name, input rev_pkt_s got, input rev_pkt_s exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at time %0t: %s got %h, expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_token_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("mismatch at time %0t: %s got %0d, expected %0d",
                          $time, name, got, exp));
    end
  endtask

  function automatic logic [Y_CORD_W-1:0] row_of(input int lane);
    return Y_CORD_W'(5 + lane);
  endfunction

  // Source coordinates of the requester echoed back as destination
  function automatic logic [X_CORD_W-1:0] src_x_of(input int lane);
    return X_CORD_W'('h30 + lane);
  endfunction

  function automatic logic [Y_CORD_W-1:0] src_y_of(input int idx);
    return Y_CORD_W'(idx);
  endfunction

  function automatic logic all_drained();
    for (int i = 0; i < NUM_LANES; i++) begin
      if (exp_rd[i] != exp_wr[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic add_req(input int lane, input xcel_op_e op, input logic [Y_CORD_W-1:0] dst_y,
                         input int addr, input logic [DATA_W-1:0] data,
                         input xcel_rsp_e status);
    req_tbl[num_reqs] = '{lane: 2'(lane), opcode: op, dst_y: dst_y, addr: ADDR_W'(addr),
                          data: data, status: status};
    num_reqs++;
  endtask

  task automatic build_table();
    // Lane isolation on address 0x10
    add_req(0, OP_STORE, row_of(0), 'h10, 32'hA5A5_0001, RSP_STORE_ACK);
    add_req(1, OP_STORE, row_of(1), 'h10, 32'h0000_1111, RSP_STORE_ACK);
    add_req(0, OP_LOAD,  row_of(0), 'h10, '0, RSP_LOAD_DATA);
    add_req(1, OP_LOAD,  row_of(1), 'h10, '0, RSP_LOAD_DATA);
    add_req(2, OP_STORE, row_of(2), 'h40, 32'hCAFE_0042, RSP_STORE_ACK);
    add_req(2, OP_LOAD,  row_of(2), 'h40, '0, RSP_LOAD_DATA);
    // Add chain returns 0, 3, 8 and leaves 15
    add_req(2, OP_ADD,   row_of(2), 'h20, 32'd3, RSP_ADD_OLD);
    add_req(2, OP_ADD,   row_of(2), 'h20, 32'd5, RSP_ADD_OLD);
    add_req(2, OP_ADD,   row_of(2), 'h20, 32'd7, RSP_ADD_OLD);
    add_req(2, OP_LOAD,  row_of(2), 'h20, '0, RSP_LOAD_DATA);
    add_req(2, OP_STORE, row_of(2) ^ 7'h40, 'h20, 32'hDEAD_0000, RSP_BAD_DEST);
    add_req(2, OP_LOAD,  row_of(2), 'h20, '0, RSP_LOAD_DATA);
    add_req(1, OP_STORE, row_of(0), 'h30, 32'hBEEF_0001, RSP_BAD_DEST);
    add_req(1, OP_LOAD,  row_of(1), 'h30, '0, RSP_LOAD_DATA);
    add_req(0, OP_LOAD,  row_of(0), 'h11, '0, RSP_LOAD_DATA);
    // Stalled lane gets more requests than the link has credits
    for (int k = 0; k < 6; k++) begin
      add_req(STALL_LANE, OP_STORE, row_of(STALL_LANE), k, $urandom, RSP_STORE_ACK);
    end
    for (int k = 0; k < 6; k++) begin
      add_req(STALL_LANE, OP_LOAD, row_of(STALL_LANE), k, '0, RSP_LOAD_DATA);
    end
  endtask

  // Reference scratchpad applied in request order per lane
  task automatic model_request(input int idx);
    req_entry_s e;
    rev_pkt_s   rsp;
    int         ln;
    e          = req_tbl[idx];
    ln         = e.lane;
    rsp.status = e.status;
    rsp.dst_x  = src_x_of(ln);
    rsp.dst_y  = src_y_of(idx);
    rsp.data   = '0;
    if (e.dst_y == row_of(ln)) begin
      case (e.opcode)
        OP_STORE: begin
          ref_mem[ln][e.addr] = e.data;
          rsp.data            = e.data;
        end
        OP_LOAD: rsp.data = ref_mem[ln][e.addr];
        default: begin
          rsp.data            = ref_mem[ln][e.addr];
          ref_mem[ln][e.addr] = ref_mem[ln][e.addr] + e.data;
        end
      endcase
    end
    exp_mem[ln][exp_wr[ln]] = rsp;
    exp_wr[ln]++;
  endtask

  // ============================================================
  // Link monitor and reverse token return
  // ============================================================

  always @(posedge clk_i) begin
    if (!reset_i) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (link_fwd_token_o[i]) begin
          fwd_tokens[i]++;
        end
        if (link_rev_v_o[i]) begin
          if (exp_rd[i] == exp_wr[i]) begin
            abort_run($sformatf("lane %0d sent a response with no request outstanding", i));
          end else begin
            check_rev_pkt($sformatf("link_rev_data_o[%0d]", i), link_rev_data_o[i],
                          exp_mem[i][exp_rd[i]]);
            exp_rd[i]++;
            rcv_count[i]++;
          end
        end
        // One token per four responses taken and none while stalled
        if (!rev_stall[i] && rev_tokens_sent[i] < rcv_count[i] / TOKEN_CREDITS) begin
          link_rev_token_i[i] <= 1'b1;
          rev_tokens_sent[i]++;
        end else begin
          link_rev_token_i[i] <= 1'b0;
        end
      end
    end
  end

  initial begin
    wait (table_built);
    #(num_reqs * 40 * CLK_PERIOD + 2000);
    abort_run("timeout: the responses did not all arrive in time");
  end

  initial begin
    int       lane;
    fwd_pkt_s pkt;
    void'($urandom(72702));
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    link_fwd_v_i     = '0;
    link_fwd_data_i  = '0;
    link_rev_token_i = '0;
    rev_stall        = NUM_LANES'(1) << STALL_LANE;
    table_built      = 1'b0;
    num_reqs         = 0;
    for (int i = 0; i < NUM_LANES; i++) begin
      global_y_cord_i[i] = row_of(i);
      exp_wr[i]          = 0;
      exp_rd[i]          = 0;
      sent[i]            = 0;
      fwd_tokens[i]      = 0;
      rcv_count[i]       = 0;
      rev_tokens_sent[i] = 0;
      for (int a = 0; a < SPAD_WORDS; a++) begin
        ref_mem[i][a] = '0;
      end
    end
    build_table();
    table_built = 1'b1;

    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (3) @(posedge clk_i);

    for (int i = 0; i < num_reqs; i++) begin
      lane = req_tbl[i].lane;
      @(negedge clk_i);
      // No strobe while the sender waits for credit
      while (RX_FIFO_DEPTH + TOKEN_CREDITS * fwd_tokens[lane] - sent[lane] <= 0) begin
        @(posedge clk_i);
        link_fwd_v_i <= '0;
        @(negedge clk_i);
      end
      model_request(i);
      pkt.opcode = req_tbl[i].opcode;
      pkt.dst_y  = req_tbl[i].dst_y;
      pkt.src_x  = src_x_of(lane);
      pkt.src_y  = src_y_of(i);
      pkt.addr   = req_tbl[i].addr;
      pkt.data   = req_tbl[i].data;
      @(posedge clk_i);
      link_fwd_v_i          <= NUM_LANES'(1) << lane;
      link_fwd_data_i[lane] <= pkt;
      sent[lane]++;
    end
    @(posedge clk_i);
    link_fwd_v_i <= '0;

    // Stalled lane must stop at the credit limit
    while (rcv_count[STALL_LANE] < RX_FIFO_DEPTH) begin
      @(negedge clk_i);
    end
    repeat (40) @(negedge clk_i);
    if (rcv_count[STALL_LANE] > RX_FIFO_DEPTH) begin
      abort_run($sformatf("lane %0d sent %0d responses without reverse tokens",
                          STALL_LANE, rcv_count[STALL_LANE]));
    end
    rev_stall = '0;

    while (!all_drained()) begin
      @(negedge clk_i);
    end
    repeat (10) @(negedge clk_i);
    for (int i = 0; i < NUM_LANES; i++) begin
      check_token_count($sformatf("link_fwd_token_o[%0d] pulses", i), fwd_tokens[i],
                        sent[i] / TOKEN_CREDITS);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/cgra_xcel_pkg.sv
hdl/noc_link_pkg.sv
hdl/link_sdr_rx.sv
hdl/link_sdr_tx.sv
hdl/xcel_endpoint.sv
hdl/cgra_pod.sv
tests/cgra_pod_tb.sv
